//--- common/neopixel_pkg.sv
package neopixel_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int unsigned AddrWidth   = 4;
    localparam int unsigned DataWidth   = 32;
    localparam int unsigned PixelWidth  = 24;
    localparam int unsigned CntWidth    = 16;
    localparam int unsigned NpxWidth    = 8;

    // Pixel FIFO sizing
    localparam int unsigned FifoDepth    = 16;
    localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);
    // One extra bit so a full FIFO can be counted
    localparam int unsigned LvlWidth     = FifoPtrWidth + 1;

    typedef logic [AddrWidth-1:0]     reg_addr_t;
    typedef logic [DataWidth-1:0]     data_t;
    typedef logic [DataWidth/8-1:0]   strb_t;
    typedef logic [PixelWidth-1:0]    pixel_t;
    typedef logic [CntWidth-1:0]      cnt_t;
    typedef logic [NpxWidth-1:0]      npx_t;
    typedef logic [LvlWidth-1:0]      lvl_t;
    typedef logic [FifoPtrWidth-1:0]  fifo_ptr_t;
    // Index of the bit inside one GRB word, 0 to 23
    typedef logic [4:0]               bit_idx_t;

    //////////////////////////////////////////////////
    // Information words
    //////////////////////////////////////////////////

    localparam data_t MaxNumNeoPixel = 32'd255;
    localparam data_t MinFreqHz      = 32'd3_000_000;
    localparam data_t BadReadValue   = 32'hBADCAB1E;

    //////////////////////////////////////////////////
    // Word offsets
    //////////////////////////////////////////////////

    localparam reg_addr_t MAX_NUM_NEOPIXEL_OFFSET = 4'd0;
    localparam reg_addr_t MIN_FREQ_OFFSET         = 4'd1;
    localparam reg_addr_t NUM_NEOPIXEL_OFFSET     = 4'd2;
    localparam reg_addr_t NEOPIXEL_T1H_OFFSET     = 4'd3;
    localparam reg_addr_t NEOPIXEL_T1L_OFFSET     = 4'd4;
    localparam reg_addr_t NEOPIXEL_T0H_OFFSET     = 4'd5;
    localparam reg_addr_t NEOPIXEL_T0L_OFFSET     = 4'd6;
    localparam reg_addr_t NEOPIXEL_T_LATCH_OFFSET = 4'd7;
    localparam reg_addr_t PIXEL_DATA_OFFSET       = 4'd8;
    localparam reg_addr_t START_OFFSET            = 4'd9;
    localparam reg_addr_t STATUS_OFFSET           = 4'd10;

    // Serial controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        HIGH,
        LOW,
        LATCH
    } ctrl_state_t;

endpackage

//--- neopixel/neopixel_fifo.sv
module neopixel_fifo (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  neopixel_pkg::pixel_t push_data_i,
    input  logic                 pop_i,
    output neopixel_pkg::pixel_t head_o,
    output logic                 empty_o,
    output logic                 full_o,
    output neopixel_pkg::lvl_t   level_o
);
    import neopixel_pkg::*;

    pixel_t    mem_q [FifoDepth];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    lvl_t      level_q;
    logic      do_push;
    logic      do_pop;

    // Overflow and underflow requests are dropped here
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == lvl_t'(FifoDepth));
    assign level_o = level_q;
    // Head word is visible without a read latency
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            // Pointers wrap naturally at the power of two depth
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Level holds when push and pop meet
            if (do_push && !do_pop) begin
                level_q <= level_q + 1'b1;
            end else if (do_pop && !do_push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

//--- neopixel/neopixel_reg.sv
module neopixel_reg (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Bus request side
    input  logic                    req_i,
    input  logic                    we_i,
    input  neopixel_pkg::reg_addr_t addr_i,
    input  neopixel_pkg::strb_t     be_i,
    input  neopixel_pkg::data_t     wdata_i,
    // Status from the datapath
    input  logic                    busy_i,
    input  logic                    fifo_full_i,
    input  neopixel_pkg::lvl_t      fifo_level_i,
    // Bus response side
    output logic                    gnt_o,
    output logic                    rvalid_o,
    output logic                    err_o,
    output neopixel_pkg::data_t     rdata_o,
    // Configuration levels
    output neopixel_pkg::npx_t      num_neopixel_o,
    output neopixel_pkg::cnt_t      t1h_o,
    output neopixel_pkg::cnt_t      t1l_o,
    output neopixel_pkg::cnt_t      t0h_o,
    output neopixel_pkg::cnt_t      t0l_o,
    output neopixel_pkg::cnt_t      t_latch_o,
    // Strobes
    output logic                    push_o,
    output neopixel_pkg::pixel_t    push_data_o,
    output logic                    start_o
);
    import neopixel_pkg::*;

    // Response phase copies of the request
    logic      req_q;
    logic      we_q;
    reg_addr_t addr_q;
    // Write error waits one cycle to meet rvalid
    logic      w_err_d, w_err_q;
    logic      rd_err;

    // Configuration storage
    npx_t num_d, num_q;
    cnt_t t1h_d, t1h_q;
    cnt_t t1l_d, t1l_q;
    cnt_t t0h_d, t0h_q;
    cnt_t t0l_d, t0l_q;
    cnt_t lat_d, lat_q;

    // Each enabled byte of the new word replaces the old byte
    function automatic data_t be_merge(data_t old_val, data_t new_val, strb_t be);
        data_t res;
        res = old_val;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Request phase
    //////////////////////////////////////////////////

    // Every request is granted at once without a stall
    assign gnt_o       = req_i;
    assign push_data_o = wdata_i[PixelWidth-1:0];

    always_comb begin
        num_d   = num_q;
        t1h_d   = t1h_q;
        t1l_d   = t1l_q;
        t0h_d   = t0h_q;
        t0l_d   = t0l_q;
        lat_d   = lat_q;
        w_err_d = 1'b0;
        push_o  = 1'b0;
        start_o = 1'b0;
        if (req_i && we_i) begin
            case (addr_i)
                NUM_NEOPIXEL_OFFSET:     num_d = npx_t'(be_merge(data_t'(num_q), wdata_i, be_i));
                NEOPIXEL_T1H_OFFSET:     t1h_d = cnt_t'(be_merge(data_t'(t1h_q), wdata_i, be_i));
                NEOPIXEL_T1L_OFFSET:     t1l_d = cnt_t'(be_merge(data_t'(t1l_q), wdata_i, be_i));
                NEOPIXEL_T0H_OFFSET:     t0h_d = cnt_t'(be_merge(data_t'(t0h_q), wdata_i, be_i));
                NEOPIXEL_T0L_OFFSET:     t0l_d = cnt_t'(be_merge(data_t'(t0l_q), wdata_i, be_i));
                NEOPIXEL_T_LATCH_OFFSET: lat_d = cnt_t'(be_merge(data_t'(lat_q), wdata_i, be_i));
                // Push ignores byte enables and a full FIFO drops the word
                PIXEL_DATA_OFFSET: begin
                    if (fifo_full_i) begin
                        w_err_d = 1'b1;
                    end else begin
                        push_o = 1'b1;
                    end
                end
                START_OFFSET:            start_o = 1'b1;
                // Information, status and unmapped words
                default:                 w_err_d = 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Response phase
    //////////////////////////////////////////////////

    always_comb begin
        rdata_o = '0;
        rd_err  = 1'b0;
        if (req_q && !we_q) begin
            case (addr_q)
                MAX_NUM_NEOPIXEL_OFFSET: rdata_o = MaxNumNeoPixel;
                MIN_FREQ_OFFSET:         rdata_o = MinFreqHz;
                NUM_NEOPIXEL_OFFSET:     rdata_o = data_t'(num_q);
                NEOPIXEL_T1H_OFFSET:     rdata_o = data_t'(t1h_q);
                NEOPIXEL_T1L_OFFSET:     rdata_o = data_t'(t1l_q);
                NEOPIXEL_T0H_OFFSET:     rdata_o = data_t'(t0h_q);
                NEOPIXEL_T0L_OFFSET:     rdata_o = data_t'(t0l_q);
                NEOPIXEL_T_LATCH_OFFSET: rdata_o = data_t'(lat_q);
                // Busy in bit 0, level in bits 12 to 8
                STATUS_OFFSET:           rdata_o = data_t'({fifo_level_i, 7'b0, busy_i});
                default: begin
                    rdata_o = BadReadValue;
                    rd_err  = 1'b1;
                end
            endcase
        end
    end

    assign rvalid_o = req_q;
    assign err_o    = (req_q && we_q) ? w_err_q : rd_err;

    assign num_neopixel_o = num_q;
    assign t1h_o          = t1h_q;
    assign t1l_o          = t1l_q;
    assign t0h_o          = t0h_q;
    assign t0l_o          = t0l_q;
    assign t_latch_o      = lat_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q   <= 1'b0;
            we_q    <= 1'b0;
            addr_q  <= '0;
            w_err_q <= 1'b0;
            num_q   <= '0;
            t1h_q   <= '0;
            t1l_q   <= '0;
            t0h_q   <= '0;
            t0l_q   <= '0;
            lat_q   <= '0;
        end else begin
            req_q   <= req_i;
            we_q    <= we_i;
            addr_q  <= addr_i;
            w_err_q <= w_err_d;
            num_q   <= num_d;
            t1h_q   <= t1h_d;
            t1l_q   <= t1l_d;
            t0h_q   <= t0h_d;
            t0l_q   <= t0l_d;
            lat_q   <= lat_d;
        end
    end

endmodule

//--- neopixel/neopixel_ctrl.sv
module neopixel_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  neopixel_pkg::npx_t   num_neopixel_i,
    input  neopixel_pkg::cnt_t   t1h_i,
    input  neopixel_pkg::cnt_t   t1l_i,
    input  neopixel_pkg::cnt_t   t0h_i,
    input  neopixel_pkg::cnt_t   t0l_i,
    input  neopixel_pkg::cnt_t   t_latch_i,
    input  neopixel_pkg::pixel_t head_i,
    input  logic                 empty_i,
    output logic                 pop_o,
    output logic                 data_o,
    output logic                 busy_o
);
    import neopixel_pkg::*;

    ctrl_state_t state_d, state_q;
    npx_t        pix_cnt_d, pix_cnt_q;
    bit_idx_t    bit_idx_d, bit_idx_q;
    pixel_t      shift_d, shift_q;
    cnt_t        phase_d, phase_q;

    // Widths with zero raised to one cycle
    cnt_t   t1h_w, t1l_w, t0h_w, t0l_w, lat_w;
    logic   phase_done;
    logic   last_pixel;
    logic   load_word;
    pixel_t next_word;

    function automatic cnt_t at_least_one(cnt_t width);
        return (width == '0) ? cnt_t'(1) : width;
    endfunction

    assign t1h_w = at_least_one(t1h_i);
    assign t1l_w = at_least_one(t1l_i);
    assign t0h_w = at_least_one(t0h_i);
    assign t0l_w = at_least_one(t0l_i);
    assign lat_w = at_least_one(t_latch_i);

    // Phase counter is loaded with the full width and ends at one
    assign phase_done = (phase_q <= cnt_t'(1));
    assign last_pixel = (npx_t'(pix_cnt_q + 1'b1) >= num_neopixel_i);
    // Underrun sends an all-zero pixel
    assign next_word  = empty_i ? '0 : head_i;

    //////////////////////////////////////////////////
    // Waveform FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d   = state_q;
        pix_cnt_d = pix_cnt_q;
        bit_idx_d = bit_idx_q;
        shift_d   = shift_q;
        phase_d   = phase_q;
        load_word = 1'b0;
        pop_o     = 1'b0;
        case (state_q)
            IDLE: begin
                // Start pulses outside IDLE fall through unnoticed
                if (start_i) begin
                    pix_cnt_d = '0;
                    if (num_neopixel_i == '0) begin
                        state_d = LATCH;
                        phase_d = lat_w;
                    end else begin
                        state_d = LOAD;
                    end
                end
            end
            LOAD: load_word = 1'b1;
            HIGH: begin
                if (phase_done) begin
                    state_d = LOW;
                    phase_d = shift_q[PixelWidth-1] ? t1l_w : t0l_w;
                end else begin
                    phase_d = phase_q - 1'b1;
                end
            end
            LOW: begin
                if (!phase_done) begin
                    phase_d = phase_q - 1'b1;
                end else if (bit_idx_q != '0) begin
                    // Next bit of the same word in MSB first order
                    state_d   = HIGH;
                    shift_d   = shift_q << 1;
                    bit_idx_d = bit_idx_q - 1'b1;
                    phase_d   = shift_q[PixelWidth-2] ? t1h_w : t0h_w;
                end else if (last_pixel) begin
                    state_d = LATCH;
                    phase_d = lat_w;
                end else begin
                    // Back to back pixels without a gap cycle
                    pix_cnt_d = pix_cnt_q + 1'b1;
                    load_word = 1'b1;
                end
            end
            LATCH: begin
                if (phase_done) begin
                    state_d = IDLE;
                end else begin
                    phase_d = phase_q - 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase

        // Pop the head word and open the first high phase
        if (load_word) begin
            pop_o     = !empty_i;
            state_d   = HIGH;
            shift_d   = next_word;
            bit_idx_d = bit_idx_t'(PixelWidth - 1);
            phase_d   = next_word[PixelWidth-1] ? t1h_w : t0h_w;
        end
    end

    assign data_o = (state_q == HIGH);
    assign busy_o = (state_q != IDLE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pix_cnt_q <= '0;
            bit_idx_q <= '0;
            shift_q   <= '0;
            phase_q   <= '0;
        end else begin
            state_q   <= state_d;
            pix_cnt_q <= pix_cnt_d;
            bit_idx_q <= bit_idx_d;
            shift_q   <= shift_d;
            phase_q   <= phase_d;
        end
    end

endmodule

//--- hw/neopixel_top.sv
module neopixel_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Register port
    input  logic                    req_i,
    input  logic                    we_i,
    input  neopixel_pkg::reg_addr_t addr_i,
    input  neopixel_pkg::strb_t     be_i,
    input  neopixel_pkg::data_t     wdata_i,
    output logic                    gnt_o,
    output logic                    rvalid_o,
    output neopixel_pkg::data_t     rdata_o,
    output logic                    err_o,
    // LED line
    output logic                    data_o,
    output logic                    busy_o
);
    import neopixel_pkg::*;

    // Register block to controller
    npx_t   num_neopixel;
    cnt_t   t1h, t1l, t0h, t0l, t_latch;
    logic   start;
    // Pixel FIFO traffic
    logic   push;
    pixel_t push_data;
    logic   pop;
    pixel_t head;
    logic   empty;
    logic   fifo_full;
    lvl_t   fifo_level;

    neopixel_reg reg_i (
        .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .be_i, .wdata_i,
        .busy_i(busy_o), .fifo_full_i(fifo_full), .fifo_level_i(fifo_level),
        .gnt_o, .rvalid_o, .err_o, .rdata_o,
        .num_neopixel_o(num_neopixel), .t1h_o(t1h), .t1l_o(t1l), .t0h_o(t0h),
        .t0l_o(t0l), .t_latch_o(t_latch),
        .push_o(push), .push_data_o(push_data), .start_o(start)
    );

    neopixel_fifo fifo_i (
        .clk_i, .rst_n_i, .push_i(push), .push_data_i(push_data), .pop_i(pop),
        .head_o(head), .empty_o(empty), .full_o(fifo_full), .level_o(fifo_level)
    );

    neopixel_ctrl ctrl_i (
        .clk_i, .rst_n_i, .start_i(start), .num_neopixel_i(num_neopixel),
        .t1h_i(t1h), .t1l_i(t1l), .t0h_i(t0h), .t0l_i(t0l), .t_latch_i(t_latch),
        .head_i(head), .empty_i(empty),
        .pop_o(pop), .data_o, .busy_o
    );

endmodule

//--- tb/tb_neopixel.sv
module tb_neopixel;
    timeunit 1ns;
    timeprecision 1ps;
    import neopixel_pkg::*;

    //////////////////////////////////////////////////
    // Test constants
    //////////////////////////////////////////////////

    localparam int ClkPeriod = 10;
    // Frame timing in clock cycles with four different widths
    localparam int T1h    = 8;
    localparam int T1l    = 4;
    localparam int T0h    = 3;
    localparam int T0l    = 6;
    localparam int TLatch = 40;
    localparam int MaxHigh  = (T1h > T0h) ? T1h : T0h;
    localparam int MaxLow   = (T1l > T0l) ? T1l : T0l;
    // Low runs beyond this are latch or idle gaps
    localparam int GapLimit = ((MaxHigh > MaxLow) ? MaxHigh : MaxLow) + 1;
    localparam int BitPeriod = (T1h + T1l > T0h + T0l) ? T1h + T1l : T0h + T0l;
    // Pixel counts of the frames in tests 4, 5 and 6
    localparam int FramePixels = 3 + 18 + 4;
    localparam longint WatchdogCycles = 20 * FramePixels * 24 * BitPeriod + 2000;

    // Information words and bad read pattern from the register map
    localparam data_t ExpMaxPixels = 32'd255;
    localparam data_t ExpMinFreq   = 32'd3_000_000;
    localparam data_t ExpBadRead   = 32'hBADC_AB1E;

    typedef bit bit_q_t [$];

    logic      clk_i;
    logic      rst_n_i;
    logic      req_i;
    logic      we_i;
    reg_addr_t addr_i;
    strb_t     be_i;
    data_t     wdata_i;
    logic      gnt_o;
    logic      rvalid_o;
    data_t     rdata_o;
    logic      err_o;
    logic      data_o;
    logic      busy_o;

    int seed            = 81108;
    int errors          = 0;
    int errors_at_start = 0;
    int test_num        = 0;
    int tests_passed    = 0;
    int tests_failed    = 0;

    // Words the FIFO should hold in push order
    pixel_t fifo_model [$];
    // Run lengths seen on the LED line
    int     high_runs [$];
    int     low_runs [$];
    data_t  reg_model [16];

    neopixel_top dut_i (
        .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .be_i, .wdata_i,
        .gnt_o, .rvalid_o, .rdata_o, .err_o, .data_o, .busy_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    initial begin : watchdog
        ctrl_state_t st;
        #(WatchdogCycles * ClkPeriod);
        st = dut_i.ctrl_i.state_q;
        $display("Simulation timed out with the controller in state %s", st.name());
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%08h, got 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %0d (%s): ok", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): %0d errors", test_num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Enabled bytes of the new word replace the old bytes
    function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                          input strb_t be);
        data_t keep;
        keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_val & ~keep) | (new_val & keep);
    endfunction

    // GRB words go out MSB first and missing pixels as zero
    function automatic bit_q_t expected_bits(input pixel_t pixels [$], input int count);
        bit_q_t bits;
        pixel_t word;
        for (int p = 0; p < count; p++) begin
            word = (p < pixels.size()) ? pixels[p] : '0;
            for (int b = 23; b >= 0; b--) begin
                bits.push_back(word[b]);
            end
        end
        return bits;
    endfunction

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    // One request cycle followed by the response sampled mid-cycle
    task automatic transfer(input logic write, input reg_addr_t addr, input data_t wdata,
                            input strb_t be, output data_t rdata, output logic err);
        @(posedge clk_i);
        #1;
        req_i   = 1'b1;
        we_i    = write;
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
        @(negedge clk_i);
        if (gnt_o !== 1'b1) begin
            report_failure("gnt_o did not follow req_i");
        end
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        we_i  = 1'b0;
        @(negedge clk_i);
        if (rvalid_o !== 1'b1) begin
            report_failure("no rvalid_o in the cycle after the request");
        end
        rdata = rdata_o;
        err   = err_o;
    endtask

    task automatic bus_write(input reg_addr_t addr, input data_t wdata, input strb_t be,
                             output logic err);
        data_t unused;
        transfer(1'b1, addr, wdata, be, unused, err);
    endtask

    task automatic bus_read(input reg_addr_t addr, output data_t rdata, output logic err);
        transfer(1'b0, addr, '0, 4'hF, rdata, err);
    endtask

    // Push with byte enables at zero as the pixel register ignores them
    task automatic push_pixel(input pixel_t pix);
        logic err;
        logic full;
        full = (fifo_model.size() >= 16);
        bus_write(PIXEL_DATA_OFFSET, {8'hA5, pix}, 4'h0, err);
        check_value("err_o", data_t'(full), data_t'(err));
        if (!full) begin
            fifo_model.push_back(pix);
        end
    endtask

    task automatic program_frame(input int count);
        logic err;
        bus_write(NUM_NEOPIXEL_OFFSET, data_t'(count), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        bus_write(NEOPIXEL_T1H_OFFSET, data_t'(T1h), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        bus_write(NEOPIXEL_T1L_OFFSET, data_t'(T1l), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        bus_write(NEOPIXEL_T0H_OFFSET, data_t'(T0h), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        bus_write(NEOPIXEL_T0L_OFFSET, data_t'(T0l), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        bus_write(NEOPIXEL_T_LATCH_OFFSET, data_t'(TLatch), 4'hF, err);
        check_value("err_o", '0, data_t'(err));
    endtask

    //////////////////////////////////////////////////
    // LED line
    //////////////////////////////////////////////////

    // Measures every high and low run of data_o
    initial begin : line_monitor
        logic level;
        int   run;
        level = 1'b0;
        run   = 0;
        forever begin
            @(negedge clk_i);
            if (data_o === level) begin
                run++;
            end else begin
                if (level === 1'b1) begin
                    high_runs.push_back(run);
                end else if (run <= GapLimit) begin
                    low_runs.push_back(run);
                end
                level = data_o;
                run   = 1;
            end
        end
    end

    // Starts a frame, waits for busy_o to fall and compares the line
    task automatic send_frame(input int count, input bit restart);
        bit_q_t exp;
        logic   err;
        int     h0;
        int     l0;
        int     n;
        int     tail;
        int     used;
        bit     got;
        exp = expected_bits(fifo_model, count);
        h0  = high_runs.size();
        l0  = low_runs.size();
        bus_write(START_OFFSET, 32'h1, 4'hF, err);
        check_value("err_o", '0, data_t'(err));
        if (busy_o !== 1'b1) begin
            report_failure("busy_o did not rise after the START write");
        end
        if (restart) begin
            // Second strobe lands while the frame is running
            bus_write(START_OFFSET, 32'h1, 4'hF, err);
            check_value("err_o", '0, data_t'(err));
        end
        // Low cycles after the last high phase including the latch
        tail = 0;
        @(negedge clk_i);
        while (busy_o === 1'b1) begin
            if (data_o === 1'b1) begin
                tail = 0;
            end else begin
                tail++;
            end
            @(negedge clk_i);
        end
        n = high_runs.size() - h0;
        check_value("decoded bit count", data_t'(exp.size()), data_t'(n));
        for (int i = 0; i < n && i < exp.size(); i++) begin
            got = (high_runs[h0 + i] == T1h);
            if (high_runs[h0 + i] != T1h && high_runs[h0 + i] != T0h) begin
                report_failure($sformatf("high run of %0d cycles fits no width",
                                         high_runs[h0 + i]));
            end else begin
                check_value($sformatf("data_o bit %0d", i), data_t'(exp[i]), data_t'(got));
            end
        end
        // The last low phase merges into the latch gap
        for (int i = 0; i + 1 < exp.size() && l0 + i < low_runs.size(); i++) begin
            check_value("data_o low run", data_t'(exp[i] ? T1l : T0l), data_t'(low_runs[l0 + i]));
        end
        if (exp.size() > 0) begin
            check_value("data_o low run count", data_t'(exp.size() - 1),
                        data_t'(low_runs.size() - l0));
            check_value("low cycles before busy_o fell",
                        data_t'((exp[exp.size() - 1] ? T1l : T0l) + TLatch), data_t'(tail));
        end
        used = (count < fifo_model.size()) ? count : fifo_model.size();
        repeat (used) begin
            void'(fifo_model.pop_front());
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : main
        data_t rd;
        logic  err;
        data_t val;
        strb_t mask;
        data_t width;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        be_i    = '0;
        wdata_i = '0;
        rst_n_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Reset state and information words
        check_value("data_o", '0, data_t'(data_o));
        check_value("busy_o", '0, data_t'(busy_o));
        check_value("gnt_o", '0, data_t'(gnt_o));
        check_value("rvalid_o", '0, data_t'(rvalid_o));
        bus_read(MAX_NUM_NEOPIXEL_OFFSET, rd, err);
        check_value("rdata_o", ExpMaxPixels, rd);
        check_value("err_o", '0, data_t'(err));
        bus_read(MIN_FREQ_OFFSET, rd, err);
        check_value("rdata_o", ExpMinFreq, rd);
        check_value("err_o", '0, data_t'(err));
        bus_read(STATUS_OFFSET, rd, err);
        check_value("rdata_o", '0, rd);
        check_value("err_o", '0, data_t'(err));
        end_test("reset and information words");

        // Count and timing registers with random data and byte masks
        for (int a = 0; a < 16; a++) begin
            reg_model[a] = '0;
        end
        repeat (3) begin
            for (int a = int'(NUM_NEOPIXEL_OFFSET); a <= int'(NEOPIXEL_T_LATCH_OFFSET); a++) begin
                val   = $random(seed);
                mask  = strb_t'($random(seed));
                width = (a == int'(NUM_NEOPIXEL_OFFSET)) ? 32'h0000_00FF : 32'h0000_FFFF;
                bus_write(reg_addr_t'(a), val, mask, err);
                check_value("err_o", '0, data_t'(err));
                reg_model[a] = merge_bytes(reg_model[a], val, mask) & width;
            end
            for (int a = int'(NUM_NEOPIXEL_OFFSET); a <= int'(NEOPIXEL_T_LATCH_OFFSET); a++) begin
                bus_read(reg_addr_t'(a), rd, err);
                check_value($sformatf("rdata_o at offset %0d", a), reg_model[a], rd);
                check_value("err_o", '0, data_t'(err));
            end
        end
        end_test("register write and read-back");

        // Read-only and unmapped writes plus write-only and unmapped reads
        for (int a = 0; a < 16; a++) begin
            if (a < 2 || a >= 10) begin
                bus_write(reg_addr_t'(a), 32'hFFFF_FFFF, 4'hF, err);
                check_value($sformatf("err_o on write to %0d", a), 32'h1, data_t'(err));
            end
            if (a == 8 || a == 9 || a >= 11) begin
                bus_read(reg_addr_t'(a), rd, err);
                check_value($sformatf("rdata_o at offset %0d", a), ExpBadRead, rd);
                check_value($sformatf("err_o on read of %0d", a), 32'h1, data_t'(err));
            end
        end
        end_test("bus errors");

        // Three random pixels
        program_frame(3);
        repeat (3) begin
            push_pixel(pixel_t'($random(seed)));
        end
        send_frame(3, 1'b0);
        end_test("frame transmission");

        // Overflow on the 17th push followed by an underrun frame
        repeat (17) begin
            push_pixel(pixel_t'($random(seed)));
        end
        bus_read(STATUS_OFFSET, rd, err);
        check_value("rdata_o", data_t'(16) << 8, rd);
        check_value("err_o", '0, data_t'(err));
        program_frame(18);
        send_frame(18, 1'b0);
        bus_read(STATUS_OFFSET, rd, err);
        check_value("rdata_o", '0, rd);
        check_value("err_o", '0, data_t'(err));
        end_test("FIFO limits and underrun");

        // Extra START during a frame
        program_frame(4);
        repeat (4) begin
            push_pixel(pixel_t'($random(seed)));
        end
        send_frame(4, 1'b1);
        end_test("start while busy");

        $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
common/neopixel_pkg.sv
neopixel/neopixel_fifo.sv
neopixel/neopixel_reg.sv
neopixel/neopixel_ctrl.sv
hw/neopixel_top.sv
tb/tb_neopixel.sv

//--- Makefile
SRCS := common/neopixel_pkg.sv neopixel/neopixel_fifo.sv neopixel/neopixel_reg.sv \
        neopixel/neopixel_ctrl.sv hw/neopixel_top.sv tb/tb_neopixel.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_neopixel: sim.f $(SRCS)
	verilator --binary --timing --top-module tb_neopixel -f sim.f

run: obj_dir/Vtb_neopixel
	obj_dir/Vtb_neopixel > sim.log; cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
